/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= aluCoreTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) test/aluRefModel.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) && echo "run ok" || { echo "run failed"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/aluCfgPkg.sv */
package aluCfgPkg;

    // Operand and result width
    localparam int dataWidth = 32;

    // Shift amount width
    // Variable shifts take the low bits of a
    localparam int shamtWidth = 5;

    // Clocks from inValid to outValid
    // One for decode, one for the result register
    localparam int pipeDepth = 2;

endpackage

/* hw/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,   // One strobe per op
    input  logic [5:0]                         opcode,
    input  logic [5:0]                         funct,
    input  logic [aluCfgPkg::shamtWidth-1:0]   shamt,
    input  logic [aluCfgPkg::dataWidth-1:0]    a,         // rs
    input  logic [aluCfgPkg::dataWidth-1:0]    b,         // rt
    output logic                               outValid,  // Two clocks after inValid
    output logic [aluCfgPkg::dataWidth-1:0]    result,
    output logic                               carryFlag,
    output logic                               overflowFlag,
    output logic                               negativeFlag,
    output logic                               zeroFlag,
    output logic                               writeEn,
    output logic                               illegalOp
);

    // Decode register outputs
    logic                                   decValid;
    mipsIsaPkg::aluOpE                      decOp;
    logic [aluCfgPkg::dataWidth-1:0]        decA;
    logic [aluCfgPkg::dataWidth-1:0]        decB;
    logic [aluCfgPkg::shamtWidth-1:0]       decShamt;

    // Combinational execute outputs
    logic [aluCfgPkg::dataWidth-1:0]        exResult;
    logic                                   exCarry;
    logic                                   exOverflow;
    logic                                   exNegative;
    logic                                   exZero;
    logic                                   exWriteEn;

    functDecode decode_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opcode   (opcode),
        .funct    (funct),
        .shamt    (shamt),
        .a        (a),
        .b        (b),
        .decValid (decValid),
        .decOp    (decOp),
        .decA     (decA),
        .decB     (decB),
        .decShamt (decShamt)
    );

    aluExecute execute_inst (
        .decOp      (decOp),
        .decA       (decA),
        .decB       (decB),
        .decShamt   (decShamt),
        .exResult   (exResult),
        .exCarry    (exCarry),
        .exOverflow (exOverflow),
        .exNegative (exNegative),
        .exZero     (exZero),
        .exWriteEn  (exWriteEn)
    );

    // Second register stage, also sees decOp for the illegal flag
    resultStage result_inst (
        .clk          (clk),
        .rstN         (rstN),
        .decValid     (decValid),
        .decOp        (decOp),
        .exResult     (exResult),
        .exCarry      (exCarry),
        .exOverflow   (exOverflow),
        .exNegative   (exNegative),
        .exZero       (exZero),
        .exWriteEn    (exWriteEn),
        .outValid     (outValid),
        .result       (result),
        .carryFlag    (carryFlag),
        .overflowFlag (overflowFlag),
        .negativeFlag (negativeFlag),
        .zeroFlag     (zeroFlag),
        .writeEn      (writeEn),
        .illegalOp    (illegalOp)
    );

endmodule

/* hw/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
    input  mipsIsaPkg::aluOpE                  decOp,
    input  logic [aluCfgPkg::dataWidth-1:0]    decA,
    input  logic [aluCfgPkg::dataWidth-1:0]    decB,
    input  logic [aluCfgPkg::shamtWidth-1:0]   decShamt,
    output logic [aluCfgPkg::dataWidth-1:0]    exResult,
    output logic                               exCarry,
    output logic                               exOverflow,
    output logic                               exNegative,
    output logic                               exZero,
    output logic                               exWriteEn
);

    logic [aluCfgPkg::dataWidth:0]          sumWide;    // Carry in top bit
    logic [aluCfgPkg::dataWidth:0]          diffWide;   // Borrow in top bit
    logic signed [aluCfgPkg::dataWidth:0]   exactSum;   // Wide enough to never overflow
    logic signed [aluCfgPkg::dataWidth:0]   exactDiff;
    logic [aluCfgPkg::dataWidth-1:0]        cntZeros;
    logic [aluCfgPkg::dataWidth-1:0]        cntOnes;
    logic [aluCfgPkg::shamtWidth-1:0]       varShamt;   // Low bits of rs
    logic                                   sltSigned;
    logic                                   sltUnsigned;

    // Leading zeros by an MSB-first priority scan
    function automatic logic [aluCfgPkg::dataWidth-1:0] leadZeros(
        input logic [aluCfgPkg::dataWidth-1:0] v
    );
        logic [aluCfgPkg::dataWidth-1:0] cnt;
        logic                            found;
        cnt   = '0;
        found = 1'b0;
        for (int i = aluCfgPkg::dataWidth - 1; i >= 0; i--)
        begin
            if (v[i])
                found = 1'b1;           // First one stops the count
            else if (!found)
                cnt = cnt + 1'b1;
        end
        return cnt;                     // 0 to 32
    endfunction

    assign sumWide  = {1'b0, decA} + {1'b0, decB};
    assign diffWide = {1'b0, decA} - {1'b0, decB};  // Top bit set when a < b unsigned

    // Sign-extended operands give the exact signed value
    assign exactSum  = $signed({decA[aluCfgPkg::dataWidth-1], decA}) +
                       $signed({decB[aluCfgPkg::dataWidth-1], decB});
    assign exactDiff = $signed({decA[aluCfgPkg::dataWidth-1], decA}) -
                       $signed({decB[aluCfgPkg::dataWidth-1], decB});

    assign cntZeros = leadZeros(decA);
    assign cntOnes  = leadZeros(~decA);  // Leading ones as zeros of the inverse

    assign varShamt = decA[aluCfgPkg::shamtWidth-1:0];

    assign sltSigned   = $signed(decA) < $signed(decB);
    assign sltUnsigned = decA < decB;

    always_comb
    begin
        exResult   = '0;
        exCarry    = 1'b0;
        exOverflow = 1'b0;
        exWriteEn  = 1'b1;              // Most ops always write
        case (decOp)
            // Logic
            mipsIsaPkg::opAnd: exResult = decA & decB;
            mipsIsaPkg::opOr:  exResult = decA | decB;
            mipsIsaPkg::opXor: exResult = decA ^ decB;
            mipsIsaPkg::opNor: exResult = ~(decA | decB);

            // Add overflows when like signs give a different sign
            mipsIsaPkg::opAdd:
            begin
                exResult   = sumWide[aluCfgPkg::dataWidth-1:0];
                exCarry    = sumWide[aluCfgPkg::dataWidth];
                exOverflow = (decA[aluCfgPkg::dataWidth-1] == decB[aluCfgPkg::dataWidth-1]) &&
                             (exResult[aluCfgPkg::dataWidth-1] != decA[aluCfgPkg::dataWidth-1]);
            end
            mipsIsaPkg::opAddu:
            begin
                exResult = sumWide[aluCfgPkg::dataWidth-1:0];
                exCarry  = sumWide[aluCfgPkg::dataWidth];  // No overflow for unsigned form
            end

            // Subtract overflows when signs differ and the result flips from a
            mipsIsaPkg::opSub:
            begin
                exResult   = diffWide[aluCfgPkg::dataWidth-1:0];
                exCarry    = diffWide[aluCfgPkg::dataWidth];
                exOverflow = (decA[aluCfgPkg::dataWidth-1] != decB[aluCfgPkg::dataWidth-1]) &&
                             (exResult[aluCfgPkg::dataWidth-1] != decA[aluCfgPkg::dataWidth-1]);
            end
            mipsIsaPkg::opSubu:
            begin
                exResult = diffWide[aluCfgPkg::dataWidth-1:0];
                exCarry  = diffWide[aluCfgPkg::dataWidth];
            end

            // Shifts always move rt
            mipsIsaPkg::opSll:  exResult = decB << decShamt;
            mipsIsaPkg::opSllv: exResult = decB << varShamt;
            mipsIsaPkg::opSrl:  exResult = decB >> decShamt;
            mipsIsaPkg::opSrlv: exResult = decB >> varShamt;
            mipsIsaPkg::opSra:  exResult = $signed(decB) >>> decShamt;  // Sign fill
            mipsIsaPkg::opSrav: exResult = $signed(decB) >>> varShamt;

            // Set on less than
            mipsIsaPkg::opSlt:  exResult = {{(aluCfgPkg::dataWidth-1){1'b0}}, sltSigned};
            mipsIsaPkg::opSltu: exResult = {{(aluCfgPkg::dataWidth-1){1'b0}}, sltUnsigned};

            // Conditional moves always pass a and gate only the write
            mipsIsaPkg::opMovn:
            begin
                exResult  = decA;
                exWriteEn = (decB != '0);
            end
            mipsIsaPkg::opMovz:
            begin
                exResult  = decA;
                exWriteEn = (decB == '0);
            end

            // Leading counts
            mipsIsaPkg::opClo: exResult = cntOnes;
            mipsIsaPkg::opClz: exResult = cntZeros;

            default:
            begin
                exWriteEn = 1'b0;       // Illegal op leaves everything zero
            end
        endcase

        // Sign and zero from whichever result was picked
        exNegative = exResult[aluCfgPkg::dataWidth-1];
        exZero     = (exResult == '0);
        if (decOp == mipsIsaPkg::opIllegal)
        begin
            exNegative = 1'b0;
            exZero     = 1'b0;          // Flag held low despite the zero result
        end
    end

    // Signed overflow only from ADD and SUB whose exact value leaves the word
    always_comb
    begin
        assert final (exOverflow ==
                      ((decOp == mipsIsaPkg::opAdd &&
                        exactSum[aluCfgPkg::dataWidth] != exactSum[aluCfgPkg::dataWidth-1]) ||
                       (decOp == mipsIsaPkg::opSub &&
                        exactDiff[aluCfgPkg::dataWidth] != exactDiff[aluCfgPkg::dataWidth-1])))
            else $error("overflow flag wrong for op %s", decOp.name());
    end

endmodule

/* hw/functDecode.sv */
`timescale 1ns/1ps

module functDecode (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,
    input  logic [5:0]                         opcode,
    input  logic [5:0]                         funct,
    input  logic [aluCfgPkg::shamtWidth-1:0]   shamt,
    input  logic [aluCfgPkg::dataWidth-1:0]    a,       // rs
    input  logic [aluCfgPkg::dataWidth-1:0]    b,       // rt
    output logic                               decValid,
    output mipsIsaPkg::aluOpE                  decOp,
    output logic [aluCfgPkg::dataWidth-1:0]    decA,
    output logic [aluCfgPkg::dataWidth-1:0]    decB,
    output logic [aluCfgPkg::shamtWidth-1:0]   decShamt
);

    mipsIsaPkg::aluOpE nextOp;  // Decoded op before the register

    // Opcode space first and then funct within it
    always_comb
    begin
        nextOp = mipsIsaPkg::opIllegal;
        if (opcode == mipsIsaPkg::opSpecial)
        begin
            case (funct)
                mipsIsaPkg::functSll:  nextOp = mipsIsaPkg::opSll;
                mipsIsaPkg::functSrl:  nextOp = mipsIsaPkg::opSrl;
                mipsIsaPkg::functSra:  nextOp = mipsIsaPkg::opSra;
                mipsIsaPkg::functSllv: nextOp = mipsIsaPkg::opSllv;
                mipsIsaPkg::functSrlv: nextOp = mipsIsaPkg::opSrlv;
                mipsIsaPkg::functSrav: nextOp = mipsIsaPkg::opSrav;
                mipsIsaPkg::functMovz: nextOp = mipsIsaPkg::opMovz;
                mipsIsaPkg::functMovn: nextOp = mipsIsaPkg::opMovn;
                mipsIsaPkg::functAdd:  nextOp = mipsIsaPkg::opAdd;
                mipsIsaPkg::functAddu: nextOp = mipsIsaPkg::opAddu;
                mipsIsaPkg::functSub:  nextOp = mipsIsaPkg::opSub;
                mipsIsaPkg::functSubu: nextOp = mipsIsaPkg::opSubu;
                mipsIsaPkg::functAnd:  nextOp = mipsIsaPkg::opAnd;
                mipsIsaPkg::functOr:   nextOp = mipsIsaPkg::opOr;
                mipsIsaPkg::functXor:  nextOp = mipsIsaPkg::opXor;
                mipsIsaPkg::functNor:  nextOp = mipsIsaPkg::opNor;
                mipsIsaPkg::functSlt:  nextOp = mipsIsaPkg::opSlt;
                mipsIsaPkg::functSltu: nextOp = mipsIsaPkg::opSltu;
                default:               nextOp = mipsIsaPkg::opIllegal;  // Undefined funct
            endcase
        end
        else if (opcode == mipsIsaPkg::opSpecial2)
        begin
            case (funct)
                mipsIsaPkg::functClz:  nextOp = mipsIsaPkg::opClz;
                mipsIsaPkg::functClo:  nextOp = mipsIsaPkg::opClo;
                default:               nextOp = mipsIsaPkg::opIllegal;
            endcase
        end
    end

    // Control registers
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            decValid <= 1'b0;
            decOp    <= mipsIsaPkg::opIllegal;
        end
        else
        begin
            decValid <= inValid;        // One-cycle strobe follows input
            if (inValid)
                decOp <= nextOp;
        end
    end

    // Operands ride alongside the op
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            decA     <= a;
            decB     <= b;
            decShamt <= shamt;
        end
    end

    // Nothing leaves decode while reset is held
    assert property (@(posedge clk) !rstN |-> !decValid)
        else $error("decValid high during reset");

endmodule

/* hw/mipsIsaPkg.sv */
package mipsIsaPkg;

    // Opcode spaces seen by the execute path
    localparam logic [5:0] opSpecial  = 6'h00;  // Classic R-type
    localparam logic [5:0] opSpecial2 = 6'h1C;  // Leading-count ops only

    // SPECIAL shifts
    localparam logic [5:0] functSll  = 6'h00;  // Shift by shamt
    localparam logic [5:0] functSrl  = 6'h02;
    localparam logic [5:0] functSra  = 6'h03;
    localparam logic [5:0] functSllv = 6'h04;  // Shift by a[4:0]
    localparam logic [5:0] functSrlv = 6'h06;
    localparam logic [5:0] functSrav = 6'h07;

    // Conditional moves
    localparam logic [5:0] functMovz = 6'h0A;
    localparam logic [5:0] functMovn = 6'h0B;

    // Add and subtract, trapping and non-trapping forms
    localparam logic [5:0] functAdd  = 6'h20;
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSub  = 6'h22;
    localparam logic [5:0] functSubu = 6'h23;

    // Bitwise logic
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functXor  = 6'h26;
    localparam logic [5:0] functNor  = 6'h27;

    // Compares
    localparam logic [5:0] functSlt  = 6'h2A;  // Signed
    localparam logic [5:0] functSltu = 6'h2B;  // Unsigned

    // SPECIAL2 space, same codes as ADD/ADDU but no clash here
    localparam logic [5:0] functClz  = 6'h20;
    localparam logic [5:0] functClo  = 6'h21;

    // Internal operation passed from decode to execute
    typedef enum logic [4:0] {
        opAnd,
        opOr,
        opXor,
        opNor,
        opAdd,      // Signed overflow reported
        opAddu,
        opSub,      // Signed overflow reported
        opSubu,
        opSll,
        opSllv,
        opSrl,
        opSrlv,
        opSra,
        opSrav,
        opSlt,
        opSltu,
        opMovn,
        opMovz,
        opClo,
        opClz,
        opIllegal   // Unknown opcode or funct
    } aluOpE;

endpackage

/* hw/resultStage.sv */
`timescale 1ns/1ps

module resultStage (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               decValid,
    input  mipsIsaPkg::aluOpE                  decOp,
    input  logic [aluCfgPkg::dataWidth-1:0]    exResult,
    input  logic                               exCarry,
    input  logic                               exOverflow,
    input  logic                               exNegative,
    input  logic                               exZero,
    input  logic                               exWriteEn,
    output logic                               outValid,
    output logic [aluCfgPkg::dataWidth-1:0]    result,
    output logic                               carryFlag,
    output logic                               overflowFlag,
    output logic                               negativeFlag,
    output logic                               zeroFlag,
    output logic                               writeEn,
    output logic                               illegalOp
);

    // Control outputs, cleared in reset
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid  <= 1'b0;
            writeEn   <= 1'b0;
            illegalOp <= 1'b0;
        end
        else
        begin
            outValid <= decValid;
            writeEn  <= decValid && exWriteEn;  // Pulses with outValid only
            if (decValid)
                illegalOp <= (decOp == mipsIsaPkg::opIllegal);  // Held between results
        end
    end

    // Payload and flags, held while idle
    always_ff @(posedge clk)
    begin
        if (decValid)
        begin
            result       <= exResult;
            carryFlag    <= exCarry;
            overflowFlag <= exOverflow;
            negativeFlag <= exNegative;
            zeroFlag     <= exZero;
        end
    end

    // An illegal op must never reach the register file
    assert property (@(posedge clk) disable iff (!rstN) !(writeEn && illegalOp))
        else $error("writeEn with illegalOp");

endmodule

/* sim.f */
+incdir+test
hw/mipsIsaPkg.sv
hw/aluCfgPkg.sv
hw/functDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/aluCore.sv
test/aluCoreTb.sv

/* test/aluRefModel.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Run of bits equal to lead, counted down from the MSB
function automatic int leadRun(input logic [31:0] v, input logic lead);
    int n;
    n = 0;
    while (n < aluCfgPkg::dataWidth && v[aluCfgPkg::dataWidth-1-n] == lead)
        n++;
    return n;                                   // 0 to 32
endfunction

// Expected outputs of one operation, worked out from the ISA rules
function automatic void predictOp(
    input  logic [5:0]  opc,
    input  logic [5:0]  fn,
    input  logic [4:0]  sh,
    input  logic [31:0] av,                     // rs
    input  logic [31:0] bv,                     // rt
    output logic [31:0] res,
    output logic        carry,
    output logic        ovf,
    output logic        neg,
    output logic        zero,
    output logic        wen,
    output logic        ill
);
    longint      wide;                          // Exact signed sum or difference
    logic [63:0] fill;                          // rt with its sign copied above
    logic [4:0]  vsh;
    res   = '0;
    carry = 1'b0;
    ovf   = 1'b0;
    wen   = 1'b1;
    ill   = 1'b0;
    vsh   = av[4:0];                            // Variable shift amount
    fill  = {{32{bv[31]}}, bv};
    if (opc == mipsIsaPkg::opSpecial)
    begin
        case (fn)
            mipsIsaPkg::functAnd:  res = av & bv;
            mipsIsaPkg::functOr:   res = av | bv;
            mipsIsaPkg::functXor:  res = av ^ bv;
            mipsIsaPkg::functNor:  res = ~(av | bv);
            mipsIsaPkg::functAdd, mipsIsaPkg::functAddu:
            begin
                wide  = longint'($signed(av)) + longint'($signed(bv));
                res   = wide[31:0];
                carry = ({32'h0, av} + {32'h0, bv}) > 64'hFFFF_FFFF;
                ovf   = (fn == mipsIsaPkg::functAdd) && (wide != longint'($signed(res)));
            end
            mipsIsaPkg::functSub, mipsIsaPkg::functSubu:
            begin
                wide  = longint'($signed(av)) - longint'($signed(bv));
                res   = wide[31:0];
                carry = av < bv;                // Borrow
                ovf   = (fn == mipsIsaPkg::functSub) && (wide != longint'($signed(res)));
            end
            mipsIsaPkg::functSll:  res = bv << sh;
            mipsIsaPkg::functSllv: res = bv << vsh;
            mipsIsaPkg::functSrl:  res = bv >> sh;
            mipsIsaPkg::functSrlv: res = bv >> vsh;
            mipsIsaPkg::functSra:  res = 32'(fill >> sh);
            mipsIsaPkg::functSrav: res = 32'(fill >> vsh);
            mipsIsaPkg::functSlt:  res = {31'b0, $signed(av) < $signed(bv)};
            mipsIsaPkg::functSltu: res = {31'b0, av < bv};
            mipsIsaPkg::functMovn:
            begin
                res = av;
                wen = (bv != 32'h0);
            end
            mipsIsaPkg::functMovz:
            begin
                res = av;
                wen = (bv == 32'h0);
            end
            default:               ill = 1'b1;
        endcase
    end
    else if (opc == mipsIsaPkg::opSpecial2)
    begin
        case (fn)
            mipsIsaPkg::functClz:  res = leadRun(av, 1'b0);
            mipsIsaPkg::functClo:  res = leadRun(av, 1'b1);
            default:               ill = 1'b1;
        endcase
    end
    else
        ill = 1'b1;
    if (ill)
    begin
        res = '0;                               // Nothing leaks from an illegal op
        wen = 1'b0;
    end
    neg  = !ill && res[31];
    zero = !ill && (res == 32'h0);
endfunction

`endif

/* test/aluCoreTb.sv */
`timescale 1ns/1ps

module aluCoreTb;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 5;
    localparam int nArith      = 300;           // Logic, add, sub, compares
    localparam int nShift      = 200;
    localparam int nCount      = 160;           // Leading counts and moves
    localparam int nIll        = 60;
    localparam int nBurst      = 64;
    localparam int totalOps    = nArith + nShift + 8 + nCount + nIll + nBurst;
    // Spaced ops take two clocks and each of six tests drains for a few more
    localparam int watchdogNs  =
        (2 * totalOps + 6 * (aluCfgPkg::pipeDepth + 6) + resetCycles + 100) * clkPeriod;

    typedef struct packed {
        logic [31:0] result;
        logic        carry;
        logic        ovf;
        logic        neg;
        logic        zero;
        logic        wen;
        logic        ill;
        logic [5:0]  opcode;
        logic [5:0]  funct;
        int          issued;                    // Negedge count at issue
    } expT;

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [31:0] a;
    logic [31:0] b;
    logic        outValid;
    logic [31:0] result;
    logic        carryFlag;
    logic        overflowFlag;
    logic        negativeFlag;
    logic        zeroFlag;
    logic        writeEn;
    logic        illegalOp;

    integer      seed;
    expT         expQ[$];                       // Predicted results in issue order
    int          pending     = 0;
    int          negCount    = 0;
    int          issuedCount = 0;
    int          checkedCount = 0;
    int          errorCount  = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          startErr    = 0;
    int          startOps    = 0;

    logic [31:0] corners [4] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    logic [5:0]  arithFuncts [10] = '{mipsIsaPkg::functAnd, mipsIsaPkg::functOr,
        mipsIsaPkg::functXor, mipsIsaPkg::functNor, mipsIsaPkg::functAdd,
        mipsIsaPkg::functAddu, mipsIsaPkg::functSub, mipsIsaPkg::functSubu,
        mipsIsaPkg::functSlt, mipsIsaPkg::functSltu};
    logic [5:0]  shiftFuncts [6] = '{mipsIsaPkg::functSll, mipsIsaPkg::functSrl,
        mipsIsaPkg::functSra, mipsIsaPkg::functSllv, mipsIsaPkg::functSrlv,
        mipsIsaPkg::functSrav};
    // Holes in the SPECIAL funct map
    logic [5:0]  holeFuncts [7] = '{6'h01, 6'h05, 6'h08, 6'h0C, 6'h18, 6'h2C, 6'h3F};

    `include "aluRefModel.svh"

    aluCore aluCore_inst (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .opcode       (opcode),
        .funct        (funct),
        .shamt        (shamt),
        .a            (a),
        .b            (b),
        .outValid     (outValid),
        .result       (result),
        .carryFlag    (carryFlag),
        .overflowFlag (overflowFlag),
        .negativeFlag (negativeFlag),
        .zeroFlag     (zeroFlag),
        .writeEn      (writeEn),
        .illegalOp    (illegalOp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Hard stop if the run stalls
    initial
    begin
        #(watchdogNs);
        $display("timeout: run still going after %0d ns", watchdogNs);
        $display("Simulation FAILED");
        $finish;
    end

    // Corner value one time in four
    function automatic logic [31:0] randOperand();
        if (($random(seed) & 3) == 0)
            return corners[$unsigned($random(seed)) % 4];
        return $random(seed);
    endfunction

    task automatic issueOp(input logic [5:0] opc, input logic [5:0] fn, input logic [4:0] sh,
                           input logic [31:0] av, input logic [31:0] bv);
        expT e;
        @(posedge clk);
        inValid <= 1'b1;
        opcode  <= opc;
        funct   <= fn;
        shamt   <= sh;
        a       <= av;
        b       <= bv;
        predictOp(opc, fn, sh, av, bv, e.result, e.carry, e.ovf, e.neg, e.zero, e.wen, e.ill);
        e.opcode = opc;
        e.funct  = fn;
        e.issued = negCount;
        expQ.push_back(e);
        pending++;
        issuedCount++;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    task automatic expectEq(input string what, input logic [31:0] got,
                            input logic [31:0] want, input expT e);
        if (got !== want)
        begin
            $display("mismatch at %0t: %s is %h, expected %h (opcode %h funct %h)",
                     $time, what, got, want, e.opcode, e.funct);
            errorCount++;
        end
    endtask

    task automatic checkIdle(input string when);
        if (outValid || writeEn || illegalOp)
        begin
            $display("mismatch at %0t: outValid, writeEn or illegalOp high %s", $time, when);
            errorCount++;
        end
    endtask

    // Drain what is in flight and print one line for the test
    task automatic finishTest(input string name);
        int waited;
        waited = 0;
        while (pending != 0 && waited < aluCfgPkg::pipeDepth + 4)
        begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0)
        begin
            $display("%0t: %0d results of test %s never came out", $time, pending, name);
            errorCount += pending;
            expQ.delete();
            pending = 0;
        end
        if (errorCount == startErr)
            testsPassed++;
        else
            testsFailed++;
        $display("test %-8s %4d ops, %0d errors, %s", name, issuedCount - startOps,
                 errorCount - startErr, (errorCount == startErr) ? "pass" : "fail");
        startErr = errorCount;
        startOps = issuedCount;
    endtask

    // Outputs settle after the rising edge and are compared on the falling one
    always @(negedge clk)
    begin
        expT e;
        negCount = negCount + 1;
        if (rstN && outValid)
        begin
            if (expQ.size() == 0)
            begin
                $display("%0t: outValid with no operation outstanding", $time);
                errorCount++;
            end
            else
            begin
                e = expQ.pop_front();
                pending--;
                checkedCount++;
                // One negedge falls between the drive edge and the sampling edge
                expectEq("latency", negCount - e.issued - 1, aluCfgPkg::pipeDepth, e);
                expectEq("result", result, e.result, e);
                expectEq("carryFlag", carryFlag, e.carry, e);
                expectEq("overflowFlag", overflowFlag, e.ovf, e);
                expectEq("negativeFlag", negativeFlag, e.neg, e);
                expectEq("zeroFlag", zeroFlag, e.zero, e);
                expectEq("writeEn", writeEn, e.wen, e);
                expectEq("illegalOp", illegalOp, e.ill, e);
            end
        end
    end

    initial
    begin
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [31:0] av;
        int          k;
        seed    = 32'h3ed2_db6a;
        rstN    = 1'b0;
        inValid = 1'b0;
        opcode  = 6'h0;
        funct   = 6'h0;
        shamt   = 5'h0;
        a       = 32'h0;
        b       = 32'h0;

        repeat (resetCycles)
        begin
            @(negedge clk);
            checkIdle("during reset");
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkIdle("right after reset");
        finishTest("reset");

        repeat (nArith)
        begin
            issueOp(mipsIsaPkg::opSpecial, arithFuncts[$unsigned($random(seed)) % 10],
                    $random(seed), randOperand(), randOperand());
            idleCycle();
        end
        finishTest("arith");

        repeat (nShift)
        begin
            issueOp(mipsIsaPkg::opSpecial, shiftFuncts[$unsigned($random(seed)) % 6],
                    $random(seed), $random(seed), randOperand());
            idleCycle();
        end
        finishTest("shift");

        // Counts of 32 and 0 come from the corners
        foreach (corners[i])
        begin
            issueOp(mipsIsaPkg::opSpecial2, mipsIsaPkg::functClz, 5'h0, corners[i], 32'h0);
            idleCycle();
            issueOp(mipsIsaPkg::opSpecial2, mipsIsaPkg::functClo, 5'h0, corners[i], 32'h0);
            idleCycle();
        end
        repeat (nCount)
        begin
            k  = $unsigned($random(seed)) % 4;
            av = $unsigned($random(seed)) >> ($unsigned($random(seed)) % 32);  // Varied run
            if (k == 0)
                issueOp(mipsIsaPkg::opSpecial2, mipsIsaPkg::functClz, 5'h0, av, $random(seed));
            else if (k == 1)
                issueOp(mipsIsaPkg::opSpecial2, mipsIsaPkg::functClo, 5'h0, ~av, $random(seed));
            else
                issueOp(mipsIsaPkg::opSpecial,
                        (k == 2) ? mipsIsaPkg::functMovn : mipsIsaPkg::functMovz, 5'h0,
                        randOperand(), ($random(seed) & 1) ? 32'h0 : randOperand());
            idleCycle();
        end
        finishTest("countmov");

        repeat (nIll)
        begin
            opc = $random(seed);
            fn  = $random(seed);
            k   = $unsigned($random(seed)) % 3;
            if (k == 0)
            begin
                opc = mipsIsaPkg::opSpecial;
                fn  = holeFuncts[$unsigned($random(seed)) % 7];
            end
            else if (k == 1)
            begin
                opc = mipsIsaPkg::opSpecial2;
                fn[5] = 1'b0;                   // Below CLZ and CLO
            end
            else if (opc == mipsIsaPkg::opSpecial || opc == mipsIsaPkg::opSpecial2)
                opc = opc ^ 6'h01;              // Nudge off a legal space
            issueOp(opc, fn, $random(seed), randOperand(), randOperand());
            idleCycle();
        end
        finishTest("illegal");

        // One op per clock with no idle cycles
        repeat (nBurst)
            issueOp(mipsIsaPkg::opSpecial, arithFuncts[$unsigned($random(seed)) % 10],
                    $random(seed), randOperand(), randOperand());
        idleCycle();
        finishTest("burst");

        if (expQ.size() != 0)
        begin
            $display("%0d expected results left over at the end", expQ.size());
            errorCount++;
        end
        $display("tests passed %0d failed %0d, results checked %0d, errors %0d",
                 testsPassed, testsFailed, checkedCount, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
